// File: logic/cpu16_settings.svh
`ifndef CPU16_SETTINGS_SVH
`define CPU16_SETTINGS_SVH

// data path and address bus width
`define CPU_WIDTH 16

// register file layout
`define CPU_NUM_REGS 8
`define CPU_IP_REG 7            // r7 doubles as the instruction pointer

// first fetch address out of reset
`define CPU_RESET_VECTOR 16'hf000

`endif

// File: logic/cpu16_pkg.sv
`default_nettype none

package cpu16_pkg;

    // alu operations, codes match the op fields of the instructions
    typedef enum logic [3:0] {
        op_zero   = 4'h0,
        op_load_a = 4'h1,
        op_inc    = 4'h2,
        op_dec    = 4'h3,
        op_asl    = 4'h4,       // 4..7 shift through carry
        op_lsr    = 4'h5,
        op_rol    = 4'h6,
        op_ror    = 4'h7,
        op_or     = 4'h8,
        op_and    = 4'h9,
        op_xor    = 4'ha,
        op_load_b = 4'hb,
        op_add    = 4'hc,       // 12..15 produce a carry
        op_sub    = 4'hd,
        op_adc    = 4'he,
        op_sbb    = 4'hf
    } alu_op_t;

    typedef enum logic [2:0] {
        st_reset        = 3'd0,
        st_select       = 3'd1,
        st_decode_wait  = 3'd2,
        st_decode       = 3'd3,
        st_compute_wait = 3'd4,
        st_compute      = 3'd5
    } cpu_state_t;

    // request to the bus port for the coming edge
    typedef enum logic [1:0] {
        bus_idle  = 2'd0,
        bus_fetch = 2'd1,
        bus_read  = 2'd2,
        bus_write = 2'd3
    } bus_cmd_t;

endpackage

`default_nettype wire

// File: logic/cpu16_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_alu
    import cpu16_pkg::*;
(
    input  wire [15:0]  a,
    input  wire [15:0]  b,
    input  wire         carry_in,
    input  wire alu_op_t op,
    output logic [16:0] result      // bit 16 is carry out
);

    always_comb begin
        case (op)
            // unary
            op_zero:   result = '0;
            op_load_a: result = {1'b0, a};
            op_inc:    result = {1'b0, a} + 17'd1;
            op_dec:    result = {1'b0, a} - 17'd1;

            // edge bit of a lands in the carry position
            op_asl:    result = {a, 1'b0};
            op_lsr:    result = {a[0], 1'b0, a[15:1]};
            op_rol:    result = {a, carry_in};
            op_ror:    result = {a[0], carry_in, a[15:1]};

            op_or:     result = {1'b0, a | b};
            op_and:    result = {1'b0, a & b};
            op_xor:    result = {1'b0, a ^ b};
            op_load_b: result = {1'b0, b};

            op_add:    result = {1'b0, a} + {1'b0, b};
            op_sub:    result = {1'b0, a} - {1'b0, b};       // borrow in bit 16
            op_adc:    result = {1'b0, a} + {1'b0, b} + {16'd0, carry_in};
            op_sbb:    result = {1'b0, a} - {1'b0, b} - {16'd0, carry_in};
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cpu16_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_settings.svh"

module cpu16_regfile (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [2:0]              rd_sel_a,
    input  wire [2:0]              rd_sel_b,
    output logic [`CPU_WIDTH-1:0]  rd_data_a,
    output logic [`CPU_WIDTH-1:0]  rd_data_b,
    input  wire                    wr_en,
    input  wire [2:0]              wr_sel,
    input  wire [`CPU_WIDTH:0]     wr_data,
    input  wire                    ip_inc,
    input  wire                    branch_take,
    input  wire [7:0]              branch_offset,
    input  wire                    flag_update,
    input  wire                    update_carry,
    output logic [`CPU_WIDTH-1:0]  ip,
    output logic                   carry,
    output logic                   zero,
    output logic                   neg
);

    logic [`CPU_WIDTH-1:0] regs [0:`CPU_NUM_REGS-2];   // r0..r6, ip kept apart
    logic [`CPU_WIDTH-1:0] offset_ext;
    logic                  wr_ip;

    assign offset_ext = {{(`CPU_WIDTH-8){branch_offset[7]}}, branch_offset};
    assign wr_ip      = (wr_sel == 3'(`CPU_IP_REG));

    // ip reads back like any other register
    assign rd_data_a = (rd_sel_a == 3'(`CPU_IP_REG)) ? ip : regs[rd_sel_a];
    assign rd_data_b = (rd_sel_b == 3'(`CPU_IP_REG)) ? ip : regs[rd_sel_b];

    always_ff @(posedge clk) begin
        if (wr_en && !wr_ip)
            regs[wr_sel] <= wr_data[`CPU_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip <= `CPU_RESET_VECTOR;
        end else if (wr_en && wr_ip) begin
            ip <= wr_data[`CPU_WIDTH-1:0];      // result into r7 is a jump
        end else if (branch_take) begin
            ip <= ip + offset_ext;              // ip already past the branch
        end else if (ip_inc) begin
            ip <= ip + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            carry <= 1'b0;
            zero  <= 1'b0;
            neg   <= 1'b0;
        end else if (flag_update) begin
            if (update_carry)
                carry <= wr_data[`CPU_WIDTH];
            zero <= ~|wr_data[`CPU_WIDTH-1:0];
            neg  <= wr_data[`CPU_WIDTH-1];
        end
    end

    // fetch increment and branch come from different sequencer states
    a_ip_one_source: assert property (@(posedge clk) disable iff (reset)
        !(ip_inc && branch_take));

endmodule

`default_nettype wire

// File: logic/cpu16_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_settings.svh"

module cpu16_sequencer
    import cpu16_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    hold,
    output logic                   busy,
    input  wire [`CPU_WIDTH-1:0]   data_in,
    input  wire                    carry,
    input  wire                    zero,
    input  wire                    neg,
    input  wire [`CPU_WIDTH-1:0]   rd_data_a,
    input  wire [`CPU_WIDTH-1:0]   rd_data_b,
    input  wire [`CPU_WIDTH-1:0]   ip,
    output logic [2:0]             rd_sel_a,
    output logic [2:0]             rd_sel_b,
    output logic                   wr_en,
    output logic [2:0]             wr_sel,
    output logic                   ip_inc,
    output logic                   branch_take,
    output logic [7:0]             branch_offset,
    output logic                   flag_update,
    output logic                   update_carry,
    output alu_op_t                alu_op,
    output logic                   b_sel_const,
    output logic                   b_sel_mem,
    output logic [7:0]             imm_const,
    output bus_cmd_t               bus_cmd,
    output logic [`CPU_WIDTH-1:0]  bus_addr,
    output logic [`CPU_WIDTH-1:0]  bus_data
);

    cpu_state_t            state;
    cpu_state_t            state_next;
    logic [`CPU_WIDTH-1:0] opcode;      // latched at decode, used in compute
    logic [`CPU_WIDTH-1:0] instr;       // instruction word visible this cycle
    logic [`CPU_WIDTH-1:0] zp_addr;
    logic                  branch_cond;

    assign instr     = (state == st_decode) ? data_in : opcode;
    assign zp_addr   = {{(`CPU_WIDTH-8){1'b0}}, instr[7:0]};
    assign rd_sel_a  = instr[10:8];
    assign rd_sel_b  = instr[2:0];
    assign wr_sel    = opcode[10:8];
    assign imm_const = opcode[7:0];
    assign branch_offset = instr[7:0];

    // tttt of zero branches always, else any enabled flag equal to bit 11
    assign branch_cond = (instr[11:8] == 4'b0000) ||
                         (instr[8]  && (instr[11] == carry)) ||
                         (instr[9]  && (instr[11] == zero)) ||
                         (instr[10] && (instr[11] == neg));

    assign b_sel_const  = opcode[15];       // 11ooo aaa form
    assign b_sel_mem    = opcode[11];       // memory operand and zero page load
    assign update_carry = alu_op[2];

    always_comb begin
        if (opcode[15])
            alu_op = alu_op_t'({1'b1, opcode[13:11]});
        else if (opcode[13])
            alu_op = op_load_b;             // zero page load
        else
            alu_op = alu_op_t'(opcode[6:3]);
    end

    always_comb begin
        state_next  = state;
        ip_inc      = 1'b0;
        branch_take = 1'b0;
        wr_en       = 1'b0;
        flag_update = 1'b0;
        bus_cmd     = bus_idle;
        bus_addr    = ip;
        bus_data    = rd_data_a;
        case (state)
            st_reset: state_next = st_select;
            st_select: begin
                if (!hold) begin            // stalled fetch keeps ip and address
                    bus_cmd    = bus_fetch;
                    ip_inc     = 1'b1;
                    state_next = st_decode_wait;
                end
            end
            st_decode_wait: state_next = st_decode;
            st_decode: begin
                casez (data_in)
                    16'b00000???_0???????: state_next = st_compute;     // a op b
                    16'b00001???_01??????: begin                        // a op [b]
                        bus_cmd    = bus_read;
                        bus_addr   = rd_data_b;
                        state_next = st_compute_wait;
                    end
                    16'b11??????_????????: state_next = st_compute;     // a op #imm8
                    16'b00101???_????????: begin
                        bus_cmd    = bus_read;
                        bus_addr   = zp_addr;
                        state_next = st_compute_wait;
                    end
                    16'b00110???_????????: begin
                        bus_cmd    = bus_write;
                        bus_addr   = zp_addr;
                        state_next = st_select;
                    end
                    16'b1000????_????????: begin
                        branch_take = branch_cond;
                        state_next  = st_select;
                    end
                    default: state_next = st_reset;     // unknown opcode
                endcase
            end
            st_compute_wait: state_next = st_compute;   // memory operand arriving
            st_compute: begin
                wr_en       = 1'b1;
                flag_update = 1'b1;
                state_next  = st_select;
            end
            default: state_next = st_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
            busy  <= 1'b1;
        end else begin
            state <= state_next;
            if (state == st_select)
                busy <= hold;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode)
            opcode <= data_in;
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {st_reset, st_select, st_decode_wait, st_decode,
                      st_compute_wait, st_compute});

    // a store ends the instruction, the next cycle is a plain select
    a_write_in_decode: assert property (@(posedge clk) disable iff (reset)
        (bus_cmd == bus_write) |-> (state == st_decode)
            ##1 (state == st_select && bus_cmd != bus_write));

endmodule

`default_nettype wire

// File: logic/cpu16_bus_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_settings.svh"

module cpu16_bus_port
    import cpu16_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire bus_cmd_t          bus_cmd,
    input  wire [`CPU_WIDTH-1:0]   bus_addr,
    input  wire [`CPU_WIDTH-1:0]   bus_data,
    output logic [`CPU_WIDTH-1:0]  address,
    output logic [`CPU_WIDTH-1:0]  data_out,
    output logic                   write
);

    always_ff @(posedge clk) begin
        if (reset) begin
            address <= '0;
            write   <= 1'b0;
        end else begin
            write <= (bus_cmd == bus_write);    // single cycle strobe
            if (bus_cmd != bus_idle)
                address <= bus_addr;            // fetch, read and write all drive it
        end
    end

    // store data only moves with a write
    always_ff @(posedge clk) begin
        if (bus_cmd == bus_write)
            data_out <= bus_data;
    end

    a_write_pulse: assert property (@(posedge clk) disable iff (reset)
        write |=> !write);

endmodule

`default_nettype wire

// File: logic/cpu16_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_settings.svh"

module cpu16_top
    import cpu16_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   hold,
    output wire                   busy,
    output wire [`CPU_WIDTH-1:0]  address,
    input  wire [`CPU_WIDTH-1:0]  data_in,
    output wire [`CPU_WIDTH-1:0]  data_out,
    output wire                   write
);

    logic [`CPU_WIDTH-1:0] rd_data_a;
    logic [`CPU_WIDTH-1:0] rd_data_b;
    logic [`CPU_WIDTH-1:0] ip;
    logic [`CPU_WIDTH-1:0] b_operand;
    logic [`CPU_WIDTH:0]   alu_result;      // carry in the top bit
    logic [`CPU_WIDTH-1:0] bus_addr;
    logic [`CPU_WIDTH-1:0] bus_data;
    logic [2:0]            rd_sel_a;
    logic [2:0]            rd_sel_b;
    logic [2:0]            wr_sel;
    logic [7:0]            branch_offset;
    logic [7:0]            imm_const;
    logic                  wr_en;
    logic                  ip_inc;
    logic                  branch_take;
    logic                  flag_update;
    logic                  update_carry;
    logic                  b_sel_const;
    logic                  b_sel_mem;
    logic                  carry;
    logic                  zero;
    logic                  neg;
    alu_op_t               alu_op;
    bus_cmd_t              bus_cmd;

    // b operand: zero-extended constant, memory word or register b
    assign b_operand = b_sel_const ? {{(`CPU_WIDTH-8){1'b0}}, imm_const} :
                       b_sel_mem   ? data_in : rd_data_b;

    cpu16_sequencer i_sequencer (
        .clk(clk), .reset(reset), .hold(hold), .busy(busy), .data_in(data_in),
        .carry(carry), .zero(zero), .neg(neg),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .ip(ip),
        .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b), .wr_en(wr_en), .wr_sel(wr_sel),
        .ip_inc(ip_inc), .branch_take(branch_take), .branch_offset(branch_offset),
        .flag_update(flag_update), .update_carry(update_carry), .alu_op(alu_op),
        .b_sel_const(b_sel_const), .b_sel_mem(b_sel_mem), .imm_const(imm_const),
        .bus_cmd(bus_cmd), .bus_addr(bus_addr), .bus_data(bus_data)
    );

    cpu16_regfile i_regfile (
        .clk(clk), .reset(reset),
        .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(alu_result),
        .ip_inc(ip_inc), .branch_take(branch_take), .branch_offset(branch_offset),
        .flag_update(flag_update), .update_carry(update_carry),
        .ip(ip), .carry(carry), .zero(zero), .neg(neg)
    );

    cpu16_alu i_alu (
        .a(rd_data_a), .b(b_operand), .carry_in(carry), .op(alu_op), .result(alu_result)
    );

    cpu16_bus_port i_bus_port (
        .clk(clk), .reset(reset), .bus_cmd(bus_cmd), .bus_addr(bus_addr),
        .bus_data(bus_data), .address(address), .data_out(data_out), .write(write)
    );

endmodule

`default_nettype wire

// File: sim/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
    input  wire         clk,
    input  wire [15:0]  address,
    input  wire [15:0]  wdata,
    input  wire         write,
    output logic [15:0] rdata,
    input  wire         clear,          // drops every stored word
    input  wire         load_en,
    input  wire [15:0]  load_addr,
    input  wire [15:0]  load_data
);

    logic [15:0] mem [logic [15:0]];    // sparse, word addressed

    // read sees the word from before a write on the same edge
    always @(posedge clk) begin
        if (mem.exists(address))
            rdata <= mem[address];
        else
            rdata <= address ^ 16'h6b2d;    // unwritten words follow the address
        if (clear)
            mem.delete();
        else if (load_en)
            mem[load_addr] = load_data;
        else if (write)
            mem[address] = wdata;
    end

endmodule

`default_nettype wire

// File: sim/tb_cpu16.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_settings.svh"

module tb_cpu16
    import cpu16_pkg::*;
;

    localparam int NUM_CASES = 9;
    localparam logic [15:0] HALT = 16'h80ff;    // branch always onto itself

    logic        clk = 1'b0;
    logic        reset;
    logic        hold;
    logic        busy;
    logic        write;
    logic [15:0] address;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        clear;
    logic        load_en;
    logic [15:0] load_addr;
    logic [15:0] load_data;

    // test table, one row per case
    logic [15:0] prog [NUM_CASES][8];
    logic        hold_case [NUM_CASES];
    int          store_no [NUM_CASES];     // which write pulse carries the result
    logic [15:0] exp_addr [NUM_CASES];
    logic [15:0] exp_data [NUM_CASES];

    logic [31:0] seed = 32'h51a3;
    int          errors = 0;
    int          timeouts = 0;

    always #4 clk = ~clk;

    cpu16_top i_dut (
        .clk(clk), .reset(reset), .hold(hold), .busy(busy), .address(address),
        .data_in(data_in), .data_out(data_out), .write(write)
    );

    tb_memory i_mem (
        .clk(clk), .address(address), .wdata(data_out), .write(write), .rdata(data_in),
        .clear(clear), .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    function automatic logic [7:0] next_byte();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];
    endfunction

    function automatic logic [15:0] enc_reg(input int a, input logic [3:0] op, input int b);
        return {5'b00000, a[2:0], 1'b0, op, b[2:0]};
    endfunction

    function automatic logic [15:0] enc_imm(input int a, input logic [3:0] op,
                                            input logic [7:0] k);
        return {2'b11, op[2:0], a[2:0], k};
    endfunction

    function automatic logic [15:0] enc_mem(input int a, input logic [3:0] op, input int b);
        return {5'b00001, a[2:0], 2'b01, op[2:0], b[2:0]};
    endfunction

    function automatic logic [15:0] enc_ldz(input int a, input logic [7:0] zp);
        return {5'b00101, a[2:0], zp};
    endfunction

    function automatic logic [15:0] enc_stz(input int a, input logic [7:0] zp);
        return {5'b00110, a[2:0], zp};
    endfunction

    function automatic logic [15:0] enc_branch(input logic [3:0] t, input logic [7:0] off);
        return {4'b1000, t, off};
    endfunction

    task automatic build_table();
        logic [7:0]  k1;
        logic [7:0]  k2;
        logic [7:0]  k3;
        logic [16:0] sum;
        logic [15:0] v;
        for (int c = 0; c < NUM_CASES; c++) begin
            hold_case[c] = 1'b0;
            store_no[c] = 1;
        end
        k1 = next_byte();
        prog[0] = '{enc_imm(1, op_load_b, k1), enc_stz(1, 8'h20),
                    HALT, HALT, HALT, HALT, HALT, HALT};
        exp_addr[0] = 16'h0020;
        exp_data[0] = {8'h00, k1};
        k1 = next_byte();
        k2 = next_byte();
        k3 = next_byte();
        prog[1] = '{enc_imm(1, op_load_b, k1), enc_imm(2, op_load_b, k2),
                    enc_reg(1, op_add, 2), enc_imm(1, op_xor, k3), enc_stz(1, 8'h21),
                    HALT, HALT, HALT};
        exp_addr[1] = 16'h0021;
        exp_data[1] = ({8'h00, k1} + {8'h00, k2}) ^ {8'h00, k3};
        k1 = next_byte();
        k2 = next_byte();
        k3 = next_byte();
        prog[2] = '{enc_imm(1, op_load_b, k1), enc_imm(2, op_load_b, k2),
                    enc_reg(1, op_sub, 2), enc_imm(1, op_or, k3), enc_reg(2, op_and, 1),
                    enc_reg(3, op_load_b, 2), enc_stz(3, 8'h22), HALT};
        exp_addr[2] = 16'h0022;
        exp_data[2] = {8'h00, k2} & (({8'h00, k1} - {8'h00, k2}) | {8'h00, k3});
        // 0 - 1 leaves ffff with the borrow in carry
        k2 = next_byte();
        k3 = next_byte();
        prog[3] = '{enc_imm(1, op_load_b, 8'h00), enc_imm(1, op_sub, 8'h01),
                    enc_imm(2, op_load_b, k2), enc_reg(2, op_add, 1),
                    enc_imm(2, op_adc, k3), enc_stz(2, 8'h23), HALT, HALT};
        sum = {9'h000, k2} + 17'h0ffff;
        exp_addr[3] = 16'h0023;
        exp_data[3] = sum[15:0] + {8'h00, k3} + {15'h0000, sum[16]};
        // ffff: asl fffe c1, lsr 7fff c0, ror 3fff c1, xor keeps carry
        k1 = next_byte();
        prog[4] = '{enc_imm(1, op_load_b, 8'h00), enc_imm(1, op_sub, 8'h01),
                    enc_reg(1, op_asl, 0), enc_reg(1, op_lsr, 0), enc_reg(1, op_ror, 0),
                    enc_imm(1, op_xor, k1), enc_reg(1, op_rol, 0), enc_stz(1, 8'h24)};
        v = 16'h3fff ^ {8'h00, k1};
        exp_addr[4] = 16'h0024;
        exp_data[4] = {v[14:0], 1'b1};
        k1 = next_byte();
        k2 = next_byte();
        prog[5] = '{enc_imm(1, op_load_b, k1), enc_imm(2, op_load_b, k2),
                    enc_reg(1, op_add, 2), enc_stz(1, 8'h40), enc_ldz(3, 8'h40),
                    enc_imm(4, op_load_b, 8'h40), enc_mem(3, op_add, 4), enc_stz(3, 8'h44)};
        v = {8'h00, k1} + {8'h00, k2};
        store_no[5] = 2;
        exp_addr[5] = 16'h0044;
        exp_data[5] = v + v;
        // zero branch taken over the marker, neg clear branch falls through
        k1 = next_byte() | 8'h01;
        prog[6] = '{enc_imm(2, op_load_b, 8'h00), enc_branch(4'b1010, 8'h01),
                    enc_imm(2, op_load_b, 8'h5a), enc_imm(2, op_sub, 8'h01),
                    enc_branch(4'b0100, 8'h01), enc_imm(2, op_xor, k1),
                    enc_stz(2, 8'h25), HALT};
        exp_addr[6] = 16'h0025;
        exp_data[6] = 16'hffff ^ {8'h00, k1};
        k1 = next_byte();
        k2 = k1 + 8'h01;        // marker never equals the sum below
        prog[7] = '{enc_imm(1, op_load_b, 8'h00), enc_imm(1, op_sub, 8'h01),
                    enc_branch(4'b1001, 8'h02), enc_imm(1, op_load_b, k2),
                    enc_stz(1, 8'h26), enc_imm(1, op_add, k1), enc_stz(1, 8'h26), HALT};
        exp_addr[7] = 16'h0026;
        exp_data[7] = 16'hffff + {8'h00, k1};
        k1 = next_byte();
        prog[8] = '{enc_imm(5, op_load_b, k1), enc_stz(5, 8'h27),
                    HALT, HALT, HALT, HALT, HALT, HALT};
        hold_case[8] = 1'b1;
        exp_addr[8] = 16'h0027;
        exp_data[8] = {8'h00, k1};
    endtask

    // called on a rising edge, returns on a rising edge
    task automatic load_program(input int c);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        load_en <= 1'b1;
        for (int i = 0; i < 9; i++) begin
            load_addr <= `CPU_RESET_VECTOR + 16'(i);
            load_data <= (i < 8) ? prog[c][i] : HALT;
            @(posedge clk);
        end
        load_en <= 1'b0;
    endtask

    task automatic run_case(input int c);
        logic [15:0] start_addr;
        int          n;
        int          seen;
        @(posedge clk);
        hold <= hold_case[c];
        load_program(c);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        start_addr = address;
        if (busy !== 1'b1) begin
            $display("[ERROR] %0t case %0d busy expected 1 got %b", $time, c, busy);
            errors++;
        end
        if (write !== 1'b0) begin
            $display("[ERROR] %0t case %0d write expected 0 got %b", $time, c, write);
            errors++;
        end
        if (hold_case[c]) begin
            repeat (6) begin
                @(negedge clk);
                if (address !== start_addr) begin
                    $display("[ERROR] %0t case %0d address expected %h got %h",
                             $time, c, start_addr, address);
                    errors++;
                end
                if (busy !== 1'b1 || write !== 1'b0) begin
                    $display("[ERROR] %0t case %0d busy/write expected 1/0 got %b/%b",
                             $time, c, busy, write);
                    errors++;
                end
            end
            @(posedge clk);
            hold <= 1'b0;
        end
        n = 0;
        while (address === start_addr && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (address === start_addr) begin
            $display("case %0d timed out waiting for the first fetch", c);
            timeouts++;
        end else if (address !== `CPU_RESET_VECTOR || busy !== 1'b0) begin
            $display("[ERROR] %0t case %0d address/busy expected %h/0 got %h/%b",
                     $time, c, `CPU_RESET_VECTOR, address, busy);
            errors++;
        end
        n = 0;
        seen = 0;
        while (seen < store_no[c] && n < 200) begin
            @(negedge clk);
            n++;
            if (write === 1'b1)
                seen++;
        end
        if (seen < store_no[c]) begin
            $display("case %0d timed out waiting for its store", c);
            timeouts++;
        end else begin
            if (address !== exp_addr[c]) begin
                $display("[ERROR] %0t case %0d address expected %h got %h",
                         $time, c, exp_addr[c], address);
                errors++;
            end
            if (data_out !== exp_data[c]) begin
                $display("[ERROR] %0t case %0d data_out expected %h got %h",
                         $time, c, exp_data[c], data_out);
                errors++;
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        hold = 1'b0;
        clear = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_table();
        for (int c = 0; c < NUM_CASES; c++)
            run_case(c);
        $display("cases %0d, errors %0d, timeouts %0d", NUM_CASES, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/cpu16_pkg.sv
logic/cpu16_alu.sv
logic/cpu16_regfile.sv
logic/cpu16_sequencer.sv
logic/cpu16_bus_port.sv
logic/cpu16_top.sv
sim/tb_memory.sv
sim/tb_cpu16.sv
